/* source/arcade_ctrl_pkg.sv */
/*
  Shared constants for the arcade player-input and control subsystem
  Joystick buttons are active low and scan codes are PS/2 set 2
*/
package arcade_ctrl_pkg;

  //////////////////////////////////////////////////
  // Joystick shift-register chain
  //////////////////////////////////////////////////
  localparam int JOY_FRAME_LEN  = 26;   // Cycles per chain frame, load included
  localparam int JOY_W          = 12;
  localparam int JOY_START      = 8;    // Start / player button
  localparam int JOY_COIN       = 9;
  localparam int JOY_SYS        = 11;   // Reset on joy1, reboot on joy2
  localparam int JOY_FIRST_SLOT = 2;    // First counter value that carries a bit

  // Frame order as {word select, bit index}; select 1 steers into joy2
  localparam logic [4:0] JOY_ORDER [JOY_FRAME_LEN-JOY_FIRST_SLOT] = '{
    {1'b0, 4'(JOY_START)}, 5'd6, 5'd5, 5'd4,
    5'd3, 5'd2, 5'd1, 5'd0,
    {1'b1, 4'(JOY_START)}, 5'd22, 5'd21, 5'd20,
    5'd19, 5'd18, 5'd17, 5'd16,
    5'd26, {1'b1, 4'(JOY_SYS)}, {1'b1, 4'(JOY_COIN)}, 5'd23,
    5'd10, {1'b0, 4'(JOY_SYS)}, {1'b0, 4'(JOY_COIN)}, 5'd7
  };

  //////////////////////////////////////////////////
  // PS/2 keyboard
  //////////////////////////////////////////////////
  localparam int PS2_FRAME_BITS = 11;   // Start, 8 data, parity, stop
  localparam int PS2_TIMEOUT    = 64;   // Idle-high cycles that abort a frame

  localparam logic [7:0] SC_BREAK  = 8'hF0;
  localparam logic [7:0] SC_EXT    = 8'hE0;
  localparam logic [7:0] SC_CTRL   = 8'h14;
  localparam logic [7:0] SC_ALT    = 8'h11;
  localparam logic [7:0] SC_DEL    = 8'h71;
  localparam logic [7:0] SC_BKSP   = 8'h66;
  localparam logic [7:0] SC_SCROLL = 8'h7E;   // Video mode toggle
  localparam logic [7:0] SC_F12    = 8'h07;   // Key mode toggle

  // Hold times
  localparam int POR_HOLD    = 256;
  localparam int REBOOT_HOLD = 8;

endpackage

/* source/joy_serial_reader.sv */
/*
  Reads two 12-bit joystick words from a parallel-load shift chain
  clocked by ena_x. Bits update one at a time as they arrive, so a word
  can mix two frames for up to one frame period.
*/
module joy_serial_reader (
  input  logic                               ena_x,
  input  logic                               pll_lckd,
  input  logic                               joy_data,
  output logic                               joy_load,
  output logic [arcade_ctrl_pkg::JOY_W-1:0]  joy1,
  output logic [arcade_ctrl_pkg::JOY_W-1:0]  joy2
);

  logic [4:0] frame_cnt;
  logic [4:0] slot_idx;
  logic [4:0] slot;       // {word select, bit index}
  logic       in_slot;

  //////////////////////////////////////////////////
  // Frame counter and load strobe
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      frame_cnt <= '0;
    end else if (frame_cnt == 5'(arcade_ctrl_pkg::JOY_FRAME_LEN - 1)) begin
      frame_cnt <= '0;
    end else begin
      frame_cnt <= frame_cnt + 5'd1;
    end
  end

  assign joy_load = (frame_cnt != '0);   // Low in slot 0 only

  //////////////////////////////////////////////////
  // Bit steering
  //////////////////////////////////////////////////
  assign in_slot  = (frame_cnt >= 5'(arcade_ctrl_pkg::JOY_FIRST_SLOT));
  assign slot_idx = frame_cnt - 5'(arcade_ctrl_pkg::JOY_FIRST_SLOT);

  always_comb begin
    slot = '0;
    if (in_slot) begin
      slot = arcade_ctrl_pkg::JOY_ORDER[slot_idx];
    end
  end

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      joy1 <= '1;   // All buttons released
      joy2 <= '1;
    end else if (in_slot) begin
      if (slot[4]) begin
        joy2[slot[3:0]] <= joy_data;
      end else begin
        joy1[slot[3:0]] <= joy_data;
      end
    end
  end

  // One load cycle per frame, every frame
  property p_load_once_per_frame;
    @(posedge ena_x) disable iff (!pll_lckd)
      !joy_load |=> joy_load [*arcade_ctrl_pkg::JOY_FRAME_LEN-1] ##1 !joy_load;
  endproperty

  a_load_once_per_frame : assert property (p_load_once_per_frame)
    else $error("joy_load strobe not once per frame");

endmodule

/* source/ps2_rx.sv */
/*
  PS/2 device-to-host receiver sampled on ena_x
  ena_x must run well above the PS/2 clock (about 10 kHz)
  Bad parity or stop bit drops the byte and flags frame_err
*/
module ps2_rx (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  output logic [7:0] rx_byte,
  output logic       byte_valid,
  output logic       frame_err
);

  localparam int IDLE_W = $clog2(arcade_ctrl_pkg::PS2_TIMEOUT);

  logic [2:0]        clk_sync;    // Two sync stages plus edge history
  logic [1:0]        data_sync;
  logic              clk_fall;
  logic              rx_bit;
  logic [3:0]        bit_cnt;     // 0 idle, 1..9 data and parity, 10 stop
  logic [IDLE_W-1:0] idle_cnt;
  logic [8:0]        shreg;       // Parity in bit 8, data LSB at bit 0
  logic              last_bit;

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      clk_sync  <= '1;
      data_sync <= '1;
    end else begin
      clk_sync  <= {clk_sync[1:0], ps2_clk};
      data_sync <= {data_sync[0], ps2_data};
    end
  end

  assign clk_fall = clk_sync[2] & ~clk_sync[1];
  assign rx_bit   = data_sync[1];
  assign last_bit = (bit_cnt == 4'(arcade_ctrl_pkg::PS2_FRAME_BITS - 1));

  //////////////////////////////////////////////////
  // Frame control
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      bit_cnt    <= '0;
      idle_cnt   <= '0;
      byte_valid <= 1'b0;
      frame_err  <= 1'b0;
    end else begin
      byte_valid <= 1'b0;
      frame_err  <= 1'b0;
      if (clk_fall) begin
        idle_cnt <= '0;
        if (bit_cnt == '0) begin
          if (!rx_bit) bit_cnt <= 4'd1;   // Start bit seen
        end else if (last_bit) begin
          bit_cnt <= '0;
          if (rx_bit && (^shreg)) begin   // Stop high and odd parity
            byte_valid <= 1'b1;
          end else begin
            frame_err <= 1'b1;
          end
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else if ((bit_cnt != '0) && clk_sync[1]) begin
        // Clock stuck high mid-frame
        if (idle_cnt == IDLE_W'(arcade_ctrl_pkg::PS2_TIMEOUT - 1)) begin
          bit_cnt  <= '0;
          idle_cnt <= '0;
        end else begin
          idle_cnt <= idle_cnt + 1'b1;
        end
      end
    end
  end

  // Data and parity shift in LSB first
  always_ff @(posedge ena_x) begin
    if (clk_fall && (bit_cnt != '0) && !last_bit) begin
      shreg <= {rx_bit, shreg[8:1]};
    end
  end

  assign rx_byte = shreg[7:0];   // Stable until the next frame starts

  a_valid_err_exclusive : assert property (
    @(posedge ena_x) disable iff (!pll_lckd) !(byte_valid && frame_err))
    else $error("byte_valid and frame_err together");

  a_valid_single : assert property (
    @(posedge ena_x) disable iff (!pll_lckd) byte_valid |=> !byte_valid)
    else $error("byte_valid longer than one cycle");

  a_err_single : assert property (
    @(posedge ena_x) disable iff (!pll_lckd) frame_err |=> !frame_err)
    else $error("frame_err longer than one cycle");

endmodule

/* source/key_switches.sv */
/*
  Scan code decoder for mode toggles and reset key combinations
  The E0 prefix is ignored so left and right modifiers act the same
*/
module key_switches (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic [7:0] rx_byte,
  input  logic       byte_valid,
  output logic       video_mode,
  output logic       key_mode,
  output logic       reset_key,
  output logic       master_reset
);

  logic brk_pend;    // Next code is a release
  logic ctrl_down;
  logic alt_down;
  logic is_prefix;
  logic is_make;
  logic combo_held;

  assign is_prefix  = (rx_byte == arcade_ctrl_pkg::SC_BREAK) ||
                      (rx_byte == arcade_ctrl_pkg::SC_EXT);
  assign is_make    = byte_valid && !is_prefix && !brk_pend;
  assign combo_held = ctrl_down && alt_down;

  //////////////////////////////////////////////////
  // Prefix and modifier tracking
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      brk_pend  <= 1'b0;
      ctrl_down <= 1'b0;
      alt_down  <= 1'b0;
    end else if (byte_valid) begin
      if (rx_byte == arcade_ctrl_pkg::SC_BREAK) begin
        brk_pend <= 1'b1;
      end else if (rx_byte != arcade_ctrl_pkg::SC_EXT) begin
        brk_pend <= 1'b0;   // Any real code consumes the break
        if (rx_byte == arcade_ctrl_pkg::SC_CTRL) ctrl_down <= !brk_pend;
        if (rx_byte == arcade_ctrl_pkg::SC_ALT)  alt_down  <= !brk_pend;
      end
    end
  end

  //////////////////////////////////////////////////
  // Toggles and reset pulses
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      video_mode   <= 1'b0;
      key_mode     <= 1'b0;
      reset_key    <= 1'b0;
      master_reset <= 1'b0;
    end else begin
      reset_key    <= 1'b0;
      master_reset <= 1'b0;
      if (is_make) begin
        case (rx_byte)
          arcade_ctrl_pkg::SC_SCROLL: video_mode   <= ~video_mode;
          arcade_ctrl_pkg::SC_F12:    key_mode     <= ~key_mode;
          arcade_ctrl_pkg::SC_DEL:    reset_key    <= combo_held;
          arcade_ctrl_pkg::SC_BKSP:   master_reset <= combo_held;
          default: ;
        endcase
      end
    end
  end

endmodule

/* source/input_mapper.sv */
/*
  Maps joysticks, board buttons and key states onto core control inputs
  Every output is registered one cycle behind its inputs
  core_reset holds for POR_HOLD+1 cycles after reset release
*/
module input_mapper (
  input  logic                              ena_x,
  input  logic                              pll_lckd,
  input  logic [arcade_ctrl_pkg::JOY_W-1:0] joy1,
  input  logic [arcade_ctrl_pkg::JOY_W-1:0] joy2,
  input  logic [1:0]                        btn,
  input  logic                              reset_key,
  input  logic                              video_mode,
  input  logic                              key_mode,
  input  logic [1:0]                        scandbl_ctrl,
  output logic                              core_reset,
  output logic [1:0]                        coin,
  output logic [1:0]                        player,
  output logic [5:0]                        joy_a,
  output logic [5:0]                        joy_b,
  output logic                              tv15khz,
  output logic [1:0]                        led
);

  logic [7:0] por_cnt;
  logic       por_done;

  //////////////////////////////////////////////////
  // Power-on hold
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      por_cnt  <= '0;
      por_done <= 1'b0;
    end else if (!por_done) begin
      por_cnt <= por_cnt + 8'd1;
      if (por_cnt == 8'(arcade_ctrl_pkg::POR_HOLD - 1)) por_done <= 1'b1;
    end
  end

  //////////////////////////////////////////////////
  // Registered mappings
  //////////////////////////////////////////////////
  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      core_reset <= 1'b1;
      coin       <= '1;   // Active low, idle
      player     <= '1;
      joy_a      <= '1;
      joy_b      <= '1;
      tv15khz    <= 1'b1;
      led        <= '0;
    end else begin
      core_reset <= !por_done || reset_key || !joy1[arcade_ctrl_pkg::JOY_SYS] || !btn[1];
      coin       <= {joy2[arcade_ctrl_pkg::JOY_COIN],
                     joy1[arcade_ctrl_pkg::JOY_COIN] & btn[0]};
      player     <= {joy2[arcade_ctrl_pkg::JOY_START], joy1[arcade_ctrl_pkg::JOY_START]};
      joy_a      <= joy1[5:0];   // Directions and fire
      joy_b      <= joy2[5:0];
      tv15khz    <= !video_mode;
      led        <= {scandbl_ctrl[0] ^ video_mode, key_mode};
    end
  end

endmodule

/* source/reboot_trigger.sv */
/*
  Turns a held reboot request into one reconfiguration pulse
  A master_reset pulse is latched until the hold completes
*/
module reboot_trigger (
  input  logic ena_x,
  input  logic pll_lckd,
  input  logic master_reset,
  input  logic joy2_sys,      // Active low
  output logic reboot
);

  localparam int HOLD_W = $clog2(arcade_ctrl_pkg::REBOOT_HOLD);

  logic              mr_latch;
  logic              armed;
  logic              req;
  logic              fire;
  logic [HOLD_W-1:0] hold_cnt;

  assign req  = master_reset || mr_latch || !joy2_sys;
  assign fire = req && armed && (hold_cnt == HOLD_W'(arcade_ctrl_pkg::REBOOT_HOLD - 1));

  always_ff @(posedge ena_x or negedge pll_lckd) begin
    if (!pll_lckd) begin
      mr_latch <= 1'b0;
      armed    <= 1'b1;
      hold_cnt <= '0;
      reboot   <= 1'b0;
    end else begin
      mr_latch <= master_reset || (mr_latch && armed && !fire);
      reboot   <= fire;
      if (!req) begin
        armed    <= 1'b1;   // Rearm once the request is gone
        hold_cnt <= '0;
      end else if (fire) begin
        armed    <= 1'b0;
        hold_cnt <= '0;
      end else if (armed) begin
        hold_cnt <= hold_cnt + 1'b1;
      end
    end
  end

  a_reboot_single : assert property (
    @(posedge ena_x) disable iff (!pll_lckd) reboot |=> !reboot)
    else $error("reboot longer than one cycle");

endmodule

/* source/arcade_ctrl_top.sv */
/*
  Player-input and control subsystem top level
  The joystick chain is clocked straight from ena_x
*/
module arcade_ctrl_top (
  input  logic       ena_x,
  input  logic       pll_lckd,
  input  logic       joy_data,
  output logic       joy_clk,
  output logic       joy_load,
  input  logic       ps2_clk,
  input  logic       ps2_data,
  input  logic [1:0] btn,
  input  logic [1:0] scandbl_ctrl,
  output logic       core_reset,
  output logic [1:0] coin,
  output logic [1:0] player,
  output logic [5:0] joy_a,
  output logic [5:0] joy_b,
  output logic       tv15khz,
  output logic [1:0] led,
  output logic       reboot
);

  logic [arcade_ctrl_pkg::JOY_W-1:0] joy1;
  logic [arcade_ctrl_pkg::JOY_W-1:0] joy2;
  logic [7:0]                        rx_byte;
  logic                              byte_valid;
  logic                              video_mode;
  logic                              key_mode;
  logic                              reset_key;
  logic                              master_reset;

  assign joy_clk = ena_x;

  //////////////////////////////////////////////////
  // Input side
  //////////////////////////////////////////////////
  joy_serial_reader joy_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .joy_data(joy_data),
    .joy_load(joy_load), .joy1(joy1), .joy2(joy2)
  );

  ps2_rx ps2_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .ps2_clk(ps2_clk), .ps2_data(ps2_data),
    .rx_byte(rx_byte), .byte_valid(byte_valid), .frame_err()
  );

  key_switches keys_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .rx_byte(rx_byte), .byte_valid(byte_valid),
    .video_mode(video_mode), .key_mode(key_mode),
    .reset_key(reset_key), .master_reset(master_reset)
  );

  // Mapping and reboot
  input_mapper map_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .joy1(joy1), .joy2(joy2), .btn(btn),
    .reset_key(reset_key), .video_mode(video_mode), .key_mode(key_mode),
    .scandbl_ctrl(scandbl_ctrl), .core_reset(core_reset), .coin(coin),
    .player(player), .joy_a(joy_a), .joy_b(joy_b), .tv15khz(tv15khz), .led(led)
  );

  reboot_trigger reboot_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .master_reset(master_reset),
    .joy2_sys(joy2[arcade_ctrl_pkg::JOY_SYS]), .reboot(reboot)
  );

endmodule

/* verification/arcade_ctrl_tb.sv */
/*
  Directed testbench for arcade_ctrl_top with joystick chain and PS/2 device models
  Joystick words keep bit 11 high except in the reset and reboot tests
*/
module arcade_ctrl_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CLK_HALF    = 4;
  localparam int PS2_HALF    = 20;   // ena_x cycles per PS/2 half period
  localparam int NUM_FRAMES  = 100;
  localparam int NUM_BYTES   = 40;
  localparam int WATCHDOG_NS = (NUM_FRAMES * arcade_ctrl_pkg::JOY_FRAME_LEN
                                + NUM_BYTES * 500 + 1000) * 2 * CLK_HALF;

  logic       ena_x, pll_lckd, joy_data, joy_clk, joy_load, ps2_clk, ps2_data;
  logic [1:0] btn, scandbl_ctrl, coin, player, led;
  logic       core_reset, tv15khz, reboot;
  logic [5:0] joy_a, joy_b;

  logic [11:0] word1, word2;   // Chain model contents
  int          chain_k, loads, mismatches, failures, reboot_cnt, reset_cycles;
  time         reboot_time, stop_fall_time;
  logic        exp_video, exp_key;
  integer      seed;

  arcade_ctrl_top dut_i (
    .ena_x(ena_x), .pll_lckd(pll_lckd), .joy_data(joy_data), .joy_clk(joy_clk),
    .joy_load(joy_load), .ps2_clk(ps2_clk), .ps2_data(ps2_data), .btn(btn),
    .scandbl_ctrl(scandbl_ctrl), .core_reset(core_reset), .coin(coin), .player(player),
    .joy_a(joy_a), .joy_b(joy_b), .tv15khz(tv15khz), .led(led), .reboot(reboot)
  );

  initial begin
    ena_x = 1'b0;
    forever #(CLK_HALF) ena_x = ~ena_x;
  end

  //////////////////////////////////////////////////
  // Joystick chain model
  //////////////////////////////////////////////////
  function automatic logic chain_bit(input int k, input logic [11:0] w1,
                                     input logic [11:0] w2);
    case (k)
      2:       return w1[8];
      10:      return w2[8];
      18:      return w2[10];
      19:      return w2[11];
      20:      return w2[9];
      21:      return w2[7];
      22:      return w1[10];
      23:      return w1[11];
      24:      return w1[9];
      25:      return w1[7];
      default: begin
        if (k >= 3 && k <= 9) return w1[9 - k];     // joy1 bits 6..0
        if (k >= 11 && k <= 17) return w2[17 - k];  // joy2 bits 6..0
        return 1'b1;
      end
    endcase
  endfunction

  always begin
    @(posedge ena_x);
    #1;
    if (!joy_load) begin   // Load cycle is slot 0
      if (chain_k != 0 && chain_k != arcade_ctrl_pkg::JOY_FRAME_LEN - 1) begin
        mismatches++;
        $display("Mismatch at %0t: joy_load came after %0d cycles, expected %0d",
                 $time, chain_k + 1, arcade_ctrl_pkg::JOY_FRAME_LEN);
      end
      chain_k = 0;
      loads   = loads + 1;
    end else begin
      chain_k = chain_k + 1;
    end
    joy_data = chain_bit(chain_k, word1, word2);
  end

  // joy_clk follows ena_x, looked at 1 ns after each edge
  always @(ena_x) begin
    #1;
    if (joy_clk !== ena_x) begin
      mismatches++;
      $display("Mismatch at %0t: joy_clk is %0b while ena_x is %0b", $time, joy_clk, ena_x);
    end
  end

  // Pulse monitors, sampled mid-cycle
  always @(negedge ena_x) begin
    if (pll_lckd && reboot) begin
      reboot_cnt  = reboot_cnt + 1;
      reboot_time = $time;
    end
    if (pll_lckd && core_reset) reset_cycles = reset_cycles + 1;
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////
  task automatic step_cycle();
    @(posedge ena_x);
    #1;
  endtask

  task automatic wait_loads(input int n);
    int target;
    target = loads + n;
    while (loads < target) step_cycle();
  endtask

  task automatic expect_eq(input string what, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      mismatches++;
      $display("Mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
    end
  endtask

  // Start, data LSB first, odd parity, stop
  task automatic send_ps2(input logic [7:0] code, input logic bad_parity);
    logic [10:0] frame;
    frame = {1'b1, (~^code) ^ bad_parity, code, 1'b0};
    for (int i = 0; i < arcade_ctrl_pkg::PS2_FRAME_BITS; i++) begin
      ps2_data = frame[i];
      repeat (PS2_HALF) step_cycle();
      ps2_clk = 1'b0;
      if (i == 10) stop_fall_time = $time;
      repeat (PS2_HALF) step_cycle();
      ps2_clk = 1'b1;
    end
    ps2_data = 1'b1;
    repeat (PS2_HALF) step_cycle();
  endtask

  task automatic release_key(input logic [7:0] code);
    send_ps2(arcade_ctrl_pkg::SC_BREAK, 1'b0);
    send_ps2(code, 1'b0);
  endtask

  task automatic check_modes(input string what);
    expect_eq({what, " tv15khz"}, tv15khz, !exp_video);
    expect_eq({what, " led"}, led, {scandbl_ctrl[0] ^ exp_video, exp_key});
  endtask

  //////////////////////////////////////////////////
  // Directed tests
  //////////////////////////////////////////////////
  task automatic power_on_hold();
    int n;
    n = 0;
    while (core_reset && n < arcade_ctrl_pkg::POR_HOLD + 20) begin
      n++;
      step_cycle();
    end
    expect_eq("power-on core_reset cycles", n, arcade_ctrl_pkg::POR_HOLD + 1);
  endtask

  task automatic reset_sources();
    btn[1] = 1'b0;
    step_cycle();
    expect_eq("core_reset after btn[1] low", core_reset, 1);
    btn[1] = 1'b1;
    repeat (2) step_cycle();
    expect_eq("core_reset after btn[1] high", core_reset, 0);
    word1[11] = 1'b0;
    wait_loads(3);
    step_cycle();
    expect_eq("core_reset with joy1 bit 11 low", core_reset, 1);
    word1[11] = 1'b1;
    wait_loads(3);
    step_cycle();
    expect_eq("core_reset with joy1 bit 11 high", core_reset, 0);
  endtask

  task automatic joystick_words();
    for (int i = 0; i < 20; i++) begin
      word1     = 12'($random(seed));
      word2     = 12'($random(seed));
      word1[11] = 1'b1;
      word2[11] = 1'b1;
      btn[0]    = i[0];   // Every other pair with the coin button pressed
      wait_loads(3);
      step_cycle();
      expect_eq("joy_a", joy_a, word1[5:0]);
      expect_eq("joy_b", joy_b, word2[5:0]);
      expect_eq("coin", coin, {word2[9], word1[9] & btn[0]});
      expect_eq("player", player, {word2[8], word1[8]});
    end
    btn[0] = 1'b1;
    word1  = '1;
    word2  = '1;
    wait_loads(3);
  endtask

  task automatic key_toggles();
    check_modes("initial");
    send_ps2(arcade_ctrl_pkg::SC_SCROLL, 1'b0);
    exp_video = ~exp_video;
    check_modes("scroll make");
    scandbl_ctrl = 2'b01;
    repeat (2) step_cycle();
    check_modes("scroll make, scandbl 1");
    scandbl_ctrl = 2'b00;
    repeat (2) step_cycle();
    send_ps2(arcade_ctrl_pkg::SC_F12, 1'b0);
    exp_key = ~exp_key;
    check_modes("F12 make");
    release_key(arcade_ctrl_pkg::SC_SCROLL);
    release_key(arcade_ctrl_pkg::SC_F12);
    check_modes("after breaks");
  endtask

  task automatic key_combos();
    int base;
    send_ps2(arcade_ctrl_pkg::SC_CTRL, 1'b0);
    send_ps2(arcade_ctrl_pkg::SC_ALT, 1'b0);
    base = reset_cycles;
    send_ps2(arcade_ctrl_pkg::SC_DEL, 1'b0);
    if (reset_cycles == base) begin
      failures++;
      $display("No core_reset pulse after Ctrl+Alt+Del at %0t", $time);
    end else begin
      expect_eq("core_reset cycles after Ctrl+Alt+Del", reset_cycles - base, 1);
    end
    release_key(arcade_ctrl_pkg::SC_DEL);
    release_key(arcade_ctrl_pkg::SC_ALT);
    base = reset_cycles;   // Ctrl still held, Alt released
    send_ps2(arcade_ctrl_pkg::SC_DEL, 1'b0);
    release_key(arcade_ctrl_pkg::SC_DEL);
    release_key(arcade_ctrl_pkg::SC_CTRL);
    expect_eq("core_reset cycles after Ctrl+Del", reset_cycles - base, 0);
  endtask

  task automatic parity_error();
    send_ps2(arcade_ctrl_pkg::SC_SCROLL, 1'b1);
    check_modes("bad parity scroll");
  endtask

  task automatic reboot_from_keys();
    int base;
    send_ps2(arcade_ctrl_pkg::SC_CTRL, 1'b0);
    send_ps2(arcade_ctrl_pkg::SC_ALT, 1'b0);
    base = reboot_cnt;
    send_ps2(arcade_ctrl_pkg::SC_BKSP, 1'b0);
    if (reboot_cnt == base) begin
      failures++;
      $display("No reboot pulse after Ctrl+Alt+Backspace at %0t", $time);
    end else if (reboot_time - stop_fall_time >
                 (3 + arcade_ctrl_pkg::REBOOT_HOLD + 4) * 2 * CLK_HALF) begin
      failures++;
      $display("Reboot pulse came too late after Ctrl+Alt+Backspace");
    end
    release_key(arcade_ctrl_pkg::SC_BKSP);
    release_key(arcade_ctrl_pkg::SC_ALT);
    release_key(arcade_ctrl_pkg::SC_CTRL);
    expect_eq("reboot pulses after Ctrl+Alt+Backspace", reboot_cnt - base, 1);
  endtask

  task automatic reboot_from_joy();
    int base;
    base      = reboot_cnt;
    word2[11] = 1'b0;
    wait_loads(3);
    if (reboot_cnt == base) begin
      failures++;
      $display("No reboot pulse with joy2 bit 11 held low at %0t", $time);
    end
    wait_loads(2);
    expect_eq("reboot pulses while joy2 bit 11 held low", reboot_cnt - base, 1);
    word2[11] = 1'b1;
    wait_loads(3);
    expect_eq("reboot pulses after joy2 bit 11 release", reboot_cnt - base, 1);
    word2[11] = 1'b0;   // Second press fires again
    wait_loads(3);
    expect_eq("reboot pulses after second joy2 press", reboot_cnt - base, 2);
    word2[11] = 1'b1;
    wait_loads(3);
  endtask

  //////////////////////////////////////////////////
  // Main sequence and watchdog
  //////////////////////////////////////////////////
  initial begin
    pll_lckd     = 1'b0;
    joy_data     = 1'b1;
    ps2_clk      = 1'b1;
    ps2_data     = 1'b1;
    btn          = 2'b11;
    scandbl_ctrl = 2'b00;
    word1        = '1;
    word2        = '1;
    chain_k      = 0;
    loads        = 0;
    mismatches   = 0;
    failures     = 0;
    reboot_cnt   = 0;
    reset_cycles = 0;
    exp_video    = 1'b0;
    exp_key      = 1'b0;
    seed         = 54;
    repeat (5) @(posedge ena_x);
    #1;
    pll_lckd = 1'b1;
    power_on_hold();
    reset_sources();
    joystick_words();
    key_toggles();
    key_combos();
    parity_error();
    reboot_from_keys();
    reboot_from_joy();
    $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: tests did not finish within %0d ns", WATCHDOG_NS);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

/* project.f */
source/arcade_ctrl_pkg.sv
source/joy_serial_reader.sv
source/ps2_rx.sv
source/key_switches.sv
source/input_mapper.sv
source/reboot_trigger.sv
source/arcade_ctrl_top.sv
verification/arcade_ctrl_tb.sv
